// ==== Bender.yml ====
package:
  name: lx_snooper

sources:
  - logic/lx_snoop_pkg.sv
  - logic/snoop_fsm.sv
  - logic/line_walker.sv
  - logic/cache_port_driver.sv
  - logic/snoop_responder.sv
  - logic/lx_snooper.sv
  - target: test
    files:
      - sim/cache_array_model.sv
      - sim/tb_lx_snooper.sv

// ==== logic/cache_port_driver.sv ====
`timescale 1ns/10ps

module cache_port_driver #(
    parameter  int DATA_WIDTH        = 32,
    parameter  int CACHE_OFFSET_BITS = 2,
    parameter  int NUMBER_OF_WAYS    = 2,
    localparam int CACHE_WIDTH = DATA_WIDTH << CACHE_OFFSET_BITS,
    localparam int WAY_BITS    = (NUMBER_OF_WAYS > 1) ? $clog2(NUMBER_OF_WAYS) : 1
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        read_start,
    input  logic                        act_valid,
    input  lx_snoop_pkg::snoop_action_t action,
    input  logic [CACHE_WIDTH-1:0]      port1_read_data,
    input  logic [WAY_BITS-1:0]         port1_matched_way,
    output logic                        port1_read,
    output logic                        port1_write,
    output logic                        port1_invalidate,
    output logic [WAY_BITS-1:0]         port1_way_select,
    output lx_snoop_pkg::line_meta_t    port1_metadata,
    output logic [CACHE_WIDTH-1:0]      port1_write_data,
    output logic [CACHE_WIDTH-1:0]      line_data
);
    import lx_snoop_pkg::*;

    logic data_valid;  // array read data on port1 this cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            port1_read       <= 1'b0;
            port1_write      <= 1'b0;
            port1_invalidate <= 1'b0;
            data_valid       <= 1'b0;
        end
        else begin
            port1_read       <= read_start;
            data_valid       <= port1_read;
            port1_write      <= act_valid && (action == ACT_SHARE);
            // writeback lines are dropped as soon as the data is taken
            port1_invalidate <= act_valid &&
                                (action == ACT_INVALIDATE || action == ACT_WRITEBACK);
        end
    end

    always_ff @(posedge clock) begin
        if (data_valid)
            port1_write_data <= port1_read_data;  // same data goes back on a share
        if (act_valid) begin
            port1_way_select <= port1_matched_way;
            if (action == ACT_SHARE)
                port1_metadata <= '{valid: 1'b1, dirty: 1'b0, coh: SHARED};
        end
    end

    // forward the line in the cycle it arrives, held copy afterwards
    assign line_data = data_valid ? port1_read_data : port1_write_data;

endmodule

// ==== logic/line_walker.sv ====
`timescale 1ns/10ps

module line_walker #(
    parameter  int CACHE_OFFSET_BITS = 2,
    parameter  int INDEX_BITS        = 8,
    parameter  int MAX_OFFSET_BITS   = 4,
    localparam int TAG_BITS = lx_snoop_pkg::ADDRESS_BITS - CACHE_OFFSET_BITS - INDEX_BITS,
    localparam int OFF_W    = $clog2(MAX_OFFSET_BITS) + 1,
    localparam int CNT_W    = MAX_OFFSET_BITS + 1
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  load,
    input  logic                                  advance,
    input  logic [lx_snoop_pkg::ADDRESS_BITS-1:0] req_address,
    input  logic [OFF_W-1:0]                      curr_offset,
    output logic [INDEX_BITS-1:0]                 index,
    output logic [TAG_BITS-1:0]                   tag,
    output logic [lx_snoop_pkg::ADDRESS_BITS-1:0] line_address,
    output logic                                  last_line
);
    import lx_snoop_pkg::*;

    logic [OFF_W-1:0] offset_q;
    logic [CNT_W-1:0] line_count;  // 1 for the first line of the transfer
    logic [CNT_W-1:0] ratio;       // lines covered by the transfer

    // index and tag follow the line address, so a wrap of the index carries into the tag
    assign index = line_address[CACHE_OFFSET_BITS +: INDEX_BITS];
    assign tag   = line_address[ADDRESS_BITS-1 -: TAG_BITS];

    always_comb begin
        int excess;
        excess = int'(offset_q) - CACHE_OFFSET_BITS;
        if (int'(offset_q) > MAX_OFFSET_BITS)
            excess = MAX_OFFSET_BITS - CACHE_OFFSET_BITS;
        ratio = (excess > 0) ? (CNT_W'(1) << excess) : CNT_W'(1);
    end

    assign last_line = (line_count == ratio);

    always_ff @(posedge clock) begin
        if (reset) begin
            line_address <= '0;
            offset_q     <= '0;
            line_count   <= '0;
        end
        else if (load) begin
            line_address <= {req_address[ADDRESS_BITS-1:CACHE_OFFSET_BITS],
                             {CACHE_OFFSET_BITS{1'b0}}};
            offset_q     <= curr_offset;
            line_count   <= CNT_W'(1);
        end
        else if (advance) begin
            line_address <= line_address + (ADDRESS_BITS'(1) << CACHE_OFFSET_BITS);
            line_count   <= line_count + CNT_W'(1);
        end
    end

endmodule

// ==== logic/lx_snoop_pkg.sv ====
package lx_snoop_pkg;

    localparam int MSG_BITS     = 4;
    localparam int ADDRESS_BITS = 32;

    // bus messages seen on the shared bus and sent back by the snooper
    typedef enum logic [MSG_BITS-1:0] {
        NO_REQ,
        R_REQ,
        RFO_BCAST,
        WS_BCAST,
        REQ_FLUSH,
        C_WB,
        C_FLUSH,
        EN_ACCESS,
        HOLD_BUS,
        MEM_RESP
    } msg_t;

    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        EXCLUSIVE,
        MODIFIED
    } coh_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        coh_t coh;
    } line_meta_t;

    // request on the bus, also used as the snoop response header
    typedef struct packed {
        msg_t                    msg;
        logic [ADDRESS_BITS-1:0] address;
    } bus_req_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        READ_LINE,
        ACTION,
        WRITE_LINE,
        INVALIDATE_LINE,
        WAIT_FOR_RESP
    } snoop_state_t;

    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_SHARE,
        ACT_INVALIDATE,
        ACT_WRITEBACK
    } snoop_action_t;

endpackage

// ==== logic/lx_snooper.sv ====
`timescale 1ns/10ps

module lx_snooper #(
    parameter  int DATA_WIDTH        = 32,
    parameter  int CACHE_OFFSET_BITS = 2,
    parameter  int INDEX_BITS        = 8,
    parameter  int NUMBER_OF_WAYS    = 2,
    parameter  int MAX_OFFSET_BITS   = 4,
    localparam int CACHE_WIDTH = DATA_WIDTH << CACHE_OFFSET_BITS,
    localparam int TAG_BITS = lx_snoop_pkg::ADDRESS_BITS - CACHE_OFFSET_BITS - INDEX_BITS,
    localparam int WAY_BITS    = (NUMBER_OF_WAYS > 1) ? $clog2(NUMBER_OF_WAYS) : 1,
    localparam int OFF_W       = $clog2(MAX_OFFSET_BITS) + 1
) (
    input  logic                     clock,
    input  logic                     reset,
    // shared bus
    input  lx_snoop_pkg::bus_req_t   bus_req,
    input  logic                     req_ready,
    input  logic                     bus_master,
    input  logic [OFF_W-1:0]         curr_offset,
    // interface side
    input  lx_snoop_pkg::msg_t       intf_msg,
    output lx_snoop_pkg::bus_req_t   snoop_resp,
    output logic [CACHE_WIDTH-1:0]   snoop_data,
    // tag array port
    output logic                     port1_read,
    output logic                     port1_write,
    output logic                     port1_invalidate,
    output logic [INDEX_BITS-1:0]    port1_index,
    output logic [TAG_BITS-1:0]      port1_tag,
    output logic [WAY_BITS-1:0]      port1_way_select,
    output lx_snoop_pkg::line_meta_t port1_metadata,
    output logic [CACHE_WIDTH-1:0]   port1_write_data,
    input  logic [CACHE_WIDTH-1:0]   port1_read_data,
    input  logic [WAY_BITS-1:0]      port1_matched_way,
    input  lx_snoop_pkg::line_meta_t port1_meta,
    input  logic                     port1_hit
);
    import lx_snoop_pkg::*;

    logic walk_load, walk_advance, last_line;
    logic read_start, act_valid;
    logic resp_load, resp_clear, resp_use_line_addr;
    snoop_action_t           action;
    msg_t                    resp_msg;
    logic [ADDRESS_BITS-1:0] line_address;
    logic [ADDRESS_BITS-1:0] req_address;  // request address for EN_ACCESS
    logic [CACHE_WIDTH-1:0]  line_data;

    always_ff @(posedge clock) begin
        if (walk_load)
            req_address <= bus_req.address;
    end

    snoop_fsm u_fsm (
        .clock              (clock),
        .reset              (reset),
        .bus_req            (bus_req),
        .bus_master         (bus_master),
        .req_ready          (req_ready),
        .intf_msg           (intf_msg),
        .port1_hit          (port1_hit),
        .port1_meta         (port1_meta),
        .last_line          (last_line),
        .walk_load          (walk_load),
        .walk_advance       (walk_advance),
        .read_start         (read_start),
        .act_valid          (act_valid),
        .action             (action),
        .resp_load          (resp_load),
        .resp_clear         (resp_clear),
        .resp_use_line_addr (resp_use_line_addr),
        .resp_msg           (resp_msg)
    );

    line_walker #(
        .CACHE_OFFSET_BITS (CACHE_OFFSET_BITS),
        .INDEX_BITS        (INDEX_BITS),
        .MAX_OFFSET_BITS   (MAX_OFFSET_BITS)
    ) u_walker (
        .clock        (clock),
        .reset        (reset),
        .load         (walk_load),
        .advance      (walk_advance),
        .req_address  (bus_req.address),
        .curr_offset  (curr_offset),
        .index        (port1_index),
        .tag          (port1_tag),
        .line_address (line_address),
        .last_line    (last_line)
    );

    cache_port_driver #(
        .DATA_WIDTH        (DATA_WIDTH),
        .CACHE_OFFSET_BITS (CACHE_OFFSET_BITS),
        .NUMBER_OF_WAYS    (NUMBER_OF_WAYS)
    ) u_port (
        .clock             (clock),
        .reset             (reset),
        .read_start        (read_start),
        .act_valid         (act_valid),
        .action            (action),
        .port1_read_data   (port1_read_data),
        .port1_matched_way (port1_matched_way),
        .port1_read        (port1_read),
        .port1_write       (port1_write),
        .port1_invalidate  (port1_invalidate),
        .port1_way_select  (port1_way_select),
        .port1_metadata    (port1_metadata),
        .port1_write_data  (port1_write_data),
        .line_data         (line_data)
    );

    snoop_responder #(
        .DATA_WIDTH        (DATA_WIDTH),
        .CACHE_OFFSET_BITS (CACHE_OFFSET_BITS)
    ) u_resp (
        .clock              (clock),
        .reset              (reset),
        .resp_load          (resp_load),
        .resp_clear         (resp_clear),
        .resp_use_line_addr (resp_use_line_addr),
        .resp_msg           (resp_msg),
        .line_address       (line_address),
        .req_address        (req_address),
        .line_data          (line_data),
        .snoop_resp         (snoop_resp),
        .snoop_data         (snoop_data)
    );

endmodule

// ==== logic/snoop_fsm.sv ====
`timescale 1ns/10ps

module snoop_fsm (
    input  logic                        clock,
    input  logic                        reset,
    input  lx_snoop_pkg::bus_req_t      bus_req,
    input  logic                        bus_master,
    input  logic                        req_ready,
    input  lx_snoop_pkg::msg_t          intf_msg,
    input  logic                        port1_hit,
    input  lx_snoop_pkg::line_meta_t    port1_meta,
    input  logic                        last_line,
    output logic                        walk_load,
    output logic                        walk_advance,
    output logic                        read_start,
    output logic                        act_valid,
    output lx_snoop_pkg::snoop_action_t action,
    output logic                        resp_load,
    output logic                        resp_clear,
    output logic                        resp_use_line_addr,
    output lx_snoop_pkg::msg_t          resp_msg
);
    import lx_snoop_pkg::*;

    snoop_state_t state, state_next;
    msg_t         req_msg;               // accepted bus message
    logic         wait_mem, wait_mem_next; // writeback outstanding, waiting on MEM_RESP
    logic         accept;
    logic         line_hit;
    logic         line_done;             // current line finished, move on or close

    // foreign requests only count while we do not own the bus
    assign accept = (state == IDLE) && !bus_master && !req_ready &&
                    (bus_req.msg inside {R_REQ, RFO_BCAST, WS_BCAST, REQ_FLUSH});

    assign line_hit = port1_hit && port1_meta.valid;

    // per-line decision, acted on only in ACTION
    always_comb begin
        if (!line_hit)
            action = ACT_NONE;
        else if (port1_meta.dirty && (req_msg == R_REQ || req_msg == REQ_FLUSH))
            action = ACT_WRITEBACK;
        else if (req_msg == R_REQ)
            action = ACT_SHARE;   // clean read hit drops to shared
        else
            action = ACT_INVALIDATE;
    end

    always_comb begin
        state_next         = state;
        wait_mem_next      = wait_mem;
        walk_load          = 1'b0;
        walk_advance       = 1'b0;
        read_start         = 1'b0;
        act_valid          = 1'b0;
        resp_load          = 1'b0;
        resp_clear         = 1'b0;
        resp_use_line_addr = 1'b0;
        resp_msg           = NO_REQ;
        line_done          = 1'b0;

        case (state)
            IDLE: begin
                if (accept) begin
                    walk_load  = 1'b1;  // walker captures the address now
                    state_next = START;
                end
            end
            START: begin
                read_start = 1'b1;
                state_next = READ_LINE;
            end
            READ_LINE: state_next = ACTION;  // tag array answers next cycle
            ACTION: begin
                act_valid = (action != ACT_NONE);
                case (action)
                    ACT_SHARE:      state_next = WRITE_LINE;
                    ACT_INVALIDATE: state_next = INVALIDATE_LINE;
                    ACT_WRITEBACK: begin
                        resp_load          = 1'b1;
                        resp_use_line_addr = 1'b1;
                        resp_msg           = (req_msg == REQ_FLUSH) ? C_FLUSH : C_WB;
                        wait_mem_next      = 1'b1;
                        state_next         = WAIT_FOR_RESP;
                    end
                    default: line_done = 1'b1;  // miss
                endcase
            end
            WRITE_LINE, INVALIDATE_LINE: line_done = 1'b1;
            WAIT_FOR_RESP: begin
                if (intf_msg == REQ_FLUSH) begin
                    // interface side flush aborts the walk
                    resp_clear    = 1'b1;
                    wait_mem_next = 1'b0;
                    state_next    = IDLE;
                end
                else if (wait_mem) begin
                    if (intf_msg == MEM_RESP) begin
                        wait_mem_next = 1'b0;
                        line_done     = 1'b1;
                        resp_load     = 1'b1;
                        resp_msg      = HOLD_BUS; // keep the bus while walking on
                    end
                end
                else if (req_ready) begin
                    resp_clear = 1'b1;
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase

        // next line, or EN_ACCESS after the last one
        if (line_done) begin
            if (last_line) begin
                resp_load  = 1'b1;
                resp_msg   = EN_ACCESS;
                state_next = WAIT_FOR_RESP;
            end
            else begin
                walk_advance = 1'b1;
                read_start   = 1'b1;
                state_next   = READ_LINE;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            req_msg  <= NO_REQ;
            wait_mem <= 1'b0;
        end
        else begin
            state    <= state_next;
            wait_mem <= wait_mem_next;
            if (accept)
                req_msg <= bus_req.msg;
        end
    end

endmodule

// ==== logic/snoop_responder.sv ====
`timescale 1ns/10ps

module snoop_responder #(
    parameter  int DATA_WIDTH        = 32,
    parameter  int CACHE_OFFSET_BITS = 2,
    localparam int CACHE_WIDTH = DATA_WIDTH << CACHE_OFFSET_BITS
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  resp_load,
    input  logic                                  resp_clear,
    input  logic                                  resp_use_line_addr,
    input  lx_snoop_pkg::msg_t                    resp_msg,
    input  logic [lx_snoop_pkg::ADDRESS_BITS-1:0] line_address,
    input  logic [lx_snoop_pkg::ADDRESS_BITS-1:0] req_address,
    input  logic [CACHE_WIDTH-1:0]                line_data,
    output lx_snoop_pkg::bus_req_t                snoop_resp,
    output logic [CACHE_WIDTH-1:0]                snoop_data
);
    import lx_snoop_pkg::*;

    logic carries_data;

    assign carries_data = (resp_msg == C_WB) || (resp_msg == C_FLUSH);

    always_ff @(posedge clock) begin
        if (reset || resp_clear) begin
            snoop_resp <= '{msg: NO_REQ, address: '0};
            snoop_data <= '0;
        end
        else if (resp_load) begin
            snoop_resp.msg     <= resp_msg;
            snoop_resp.address <= resp_use_line_addr ? line_address : req_address;
            snoop_data         <= carries_data ? line_data : '0;  // data only with a writeback
        end
    end

endmodule

// ==== lx_snooper.f ====
logic/lx_snoop_pkg.sv
logic/snoop_fsm.sv
logic/line_walker.sv
logic/cache_port_driver.sv
logic/snoop_responder.sv
logic/lx_snooper.sv
sim/cache_array_model.sv
sim/tb_lx_snooper.sv

// ==== sim/cache_array_model.sv ====
`timescale 1ns/10ps

module cache_array_model #(
    parameter  int DATA_WIDTH        = 32,
    parameter  int CACHE_OFFSET_BITS = 2,
    parameter  int INDEX_BITS        = 8,
    parameter  int NUMBER_OF_WAYS    = 2,
    localparam int CACHE_WIDTH = DATA_WIDTH << CACHE_OFFSET_BITS,
    localparam int TAG_BITS = lx_snoop_pkg::ADDRESS_BITS - CACHE_OFFSET_BITS - INDEX_BITS,
    localparam int WAY_BITS    = (NUMBER_OF_WAYS > 1) ? $clog2(NUMBER_OF_WAYS) : 1,
    localparam int SETS        = 1 << INDEX_BITS
) (
    input  logic                     clock,
    input  logic                     read,
    input  logic                     write,
    input  logic                     invalidate,
    input  logic [INDEX_BITS-1:0]    index,
    input  logic [TAG_BITS-1:0]      tag,
    input  logic [WAY_BITS-1:0]      way_select,
    input  lx_snoop_pkg::line_meta_t metadata,
    input  logic [CACHE_WIDTH-1:0]   write_data,
    output logic [CACHE_WIDTH-1:0]   read_data,
    output logic [WAY_BITS-1:0]      matched_way,
    output lx_snoop_pkg::line_meta_t meta,
    output logic                     hit
);
    import lx_snoop_pkg::*;

    // filled by the testbench before reset is released
    logic [TAG_BITS-1:0]    tag_mem  [NUMBER_OF_WAYS][SETS];
    line_meta_t             meta_mem [NUMBER_OF_WAYS][SETS];
    logic [CACHE_WIDTH-1:0] data_mem [NUMBER_OF_WAYS][SETS];

    always @(posedge clock) begin
        if (read) begin
            hit         <= 1'b0;  // miss answers with zeros
            matched_way <= '0;
            meta        <= '0;
            read_data   <= '0;
            for (int w = 0; w < NUMBER_OF_WAYS; w++) begin
                if (meta_mem[w][index].valid && tag_mem[w][index] == tag) begin
                    hit         <= 1'b1;
                    matched_way <= WAY_BITS'(w);
                    meta        <= meta_mem[w][index];
                    read_data   <= data_mem[w][index];
                end
            end
        end
        if (write) begin
            meta_mem[way_select][index] <= metadata;
            data_mem[way_select][index] <= write_data;
        end
        if (invalidate)
            meta_mem[way_select][index].valid <= 1'b0;  // tag and data stay
    end

endmodule

// ==== sim/tb_lx_snooper.sv ====
`timescale 1ns/10ps

module tb_lx_snooper;
    import lx_snoop_pkg::*;

    localparam int NUM_REQ        = 40;
    localparam int MAX_LINES      = 4;
    localparam int MAX_RESP_DELAY = 40;  // all MEM_RESP and req_ready waits of one request
    localparam int WATCHDOG_CYCLES = NUM_REQ * (MAX_LINES * 3 + MAX_RESP_DELAY + 10);

    logic         clock = 1'b0;
    logic         reset;
    bus_req_t     bus_req;
    logic         req_ready, bus_master;
    logic [2:0]   curr_offset;
    msg_t         intf_msg;
    bus_req_t     snoop_resp;
    logic [127:0] snoop_data, port1_write_data, port1_read_data;
    logic         port1_read, port1_write, port1_invalidate, port1_hit;
    logic [7:0]   port1_index;
    logic [21:0]  port1_tag;
    logic         port1_way_select, port1_matched_way;
    line_meta_t   port1_metadata, port1_meta;

    // reference copy of the array
    logic [21:0]  ref_tag  [2][256];
    line_meta_t   ref_meta [2][256];
    logic [127:0] ref_data [2][256];

    integer seed;
    int     errors, checks;
    logic   stuck;  // set when a wait runs out and ends the request loop

    always #5 clock = ~clock;

    lx_snooper u_lx_snooper (
        .clock (clock), .reset (reset), .bus_req (bus_req), .req_ready (req_ready),
        .bus_master (bus_master), .curr_offset (curr_offset), .intf_msg (intf_msg),
        .snoop_resp (snoop_resp), .snoop_data (snoop_data), .port1_read (port1_read),
        .port1_write (port1_write), .port1_invalidate (port1_invalidate),
        .port1_index (port1_index), .port1_tag (port1_tag),
        .port1_way_select (port1_way_select), .port1_metadata (port1_metadata),
        .port1_write_data (port1_write_data), .port1_read_data (port1_read_data),
        .port1_matched_way (port1_matched_way), .port1_meta (port1_meta),
        .port1_hit (port1_hit)
    );

    cache_array_model u_array (
        .clock (clock), .read (port1_read), .write (port1_write),
        .invalidate (port1_invalidate), .index (port1_index), .tag (port1_tag),
        .way_select (port1_way_select), .metadata (port1_metadata),
        .write_data (port1_write_data), .read_data (port1_read_data),
        .matched_way (port1_matched_way), .meta (port1_meta), .hit (port1_hit)
    );

    task automatic check(input logic ok, input string msg);
        checks++;
        if (!ok) begin
            errors++;
            $display("ERR %0t: %s", $time, msg);
        end
    endtask

    task automatic fill_arrays();
        for (int s = 0; s < 256; s++) begin
            for (int w = 0; w < 2; w++) begin
                // small tag pool gives many hits; ways of a set never share a tag
                ref_tag[w][s]  = (w == 0) ? 22'($random(seed) & 3) : ref_tag[0][s] ^ 22'd1;
                ref_meta[w][s] = line_meta_t'(4'($random(seed)));
                ref_data[w][s] = {$random(seed), $random(seed), $random(seed), $random(seed)};
                u_array.tag_mem[w][s]  = ref_tag[w][s];
                u_array.meta_mem[w][s] = ref_meta[w][s];
                u_array.data_mem[w][s] = ref_data[w][s];
            end
        end
    endtask

    function automatic int find_way(input logic [7:0] idx, input logic [21:0] tg);
        for (int w = 0; w < 2; w++)
            if (ref_meta[w][idx].valid && ref_tag[w][idx] == tg)
                return w;
        return -1;
    endfunction

    function automatic logic probe(input int sel, input msg_t target);
        case (sel)
            0:       return port1_read;
            1:       return port1_write;
            2:       return port1_invalidate;
            default: return snoop_resp.msg == target;
        endcase
    endfunction

    // looks at the current sample first, then at following falling edges
    task automatic wait_for(input int sel, input msg_t target, input string what);
        int n;
        n = 0;
        while (!probe(sel, target) && n < 64) begin
            @(negedge clock);
            n++;
        end
        if (!probe(sel, target)) begin
            $display("timed out waiting for %s", what);
            errors++;
            stuck = 1'b1;
        end
    endtask

    task automatic pulse_intf(input msg_t m, input int delay);
        repeat (delay) @(posedge clock);
        @(posedge clock);
        intf_msg <= m;
        @(posedge clock);
        intf_msg <= NO_REQ;
        @(negedge clock);
    endtask

    // request while we own the bus or req_ready is up must be ignored
    task automatic filtered_request();
        int blk;
        blk = 1 + ($unsigned($random(seed)) % 3);
        @(posedge clock);
        bus_req    <= '{msg: msg_t'(1 + ($random(seed) & 3)), address: $random(seed)};
        bus_master <= blk[0];
        req_ready  <= blk[1];
        repeat (4) begin
            @(negedge clock);
            check(!port1_read && !port1_write && !port1_invalidate,
                  "port1 strobe on a filtered request");
            check(snoop_resp.msg == NO_REQ, "response to a filtered request");
        end
        @(posedge clock);
        bus_req    <= '{msg: NO_REQ, address: '0};
        bus_master <= 1'b0;
        req_ready  <= 1'b0;
    endtask

    task automatic run_request(input int t);
        msg_t          msg;
        snoop_action_t act;
        logic [31:0]   addr, la;
        logic [2:0]    off;
        logic [7:0]    idx;
        logic [21:0]   tg;
        int            lines, ex, w, err0, hold;
        logic          abort;
        err0  = errors;
        abort = 1'b0;
        case ($random(seed) & 3)
            0:       msg = R_REQ;
            1:       msg = RFO_BCAST;
            2:       msg = WS_BCAST;
            default: msg = REQ_FLUSH;
        endcase
        addr  = {20'd0, 2'($random(seed)), 10'($random(seed))};
        off   = 3'($random(seed));
        ex    = ((off > 4) ? 4 : int'(off)) - 2;
        lines = (ex > 0) ? (1 << ex) : 1;
        if (($random(seed) & 3) == 0)
            filtered_request();
        @(posedge clock);
        bus_req     <= '{msg: msg, address: addr};
        curr_offset <= off;
        @(posedge clock);  // accepted here
        bus_req <= '{msg: NO_REQ, address: '0};
        @(negedge clock);
        check(!port1_read, "port1_read one cycle after accept");
        @(negedge clock);
        check(port1_read, "no port1_read 2 cycles after accept");
        for (int l = 0; l < lines && !stuck && !abort; l++) begin
            la  = {addr[31:2], 2'b00} + (l << 2);
            idx = la[9:2];
            tg  = la[31:10];
            w   = find_way(idx, tg);
            if (w < 0)
                act = ACT_NONE;
            else if (ref_meta[w][idx].dirty && (msg == R_REQ || msg == REQ_FLUSH))
                act = ACT_WRITEBACK;
            else if (msg == R_REQ)
                act = ACT_SHARE;
            else
                act = ACT_INVALIDATE;
            wait_for(0, NO_REQ, "port1_read");
            if (stuck)
                return;
            check(port1_index == idx && port1_tag == tg, "wrong line read");
            @(negedge clock);
            if (act == ACT_SHARE) begin
                wait_for(1, NO_REQ, "port1_write");
                check(port1_way_select == w && port1_write_data == ref_data[w][idx],
                      "share writes wrong way or data");
                check(port1_metadata == line_meta_t'{valid: 1'b1, dirty: 1'b0, coh: SHARED},
                      "share writes wrong metadata");
                ref_meta[w][idx] = '{valid: 1'b1, dirty: 1'b0, coh: SHARED};
                @(negedge clock);
            end
            else if (act == ACT_INVALIDATE || act == ACT_WRITEBACK) begin
                wait_for(2, NO_REQ, "port1_invalidate");
                check(port1_way_select == w, "invalidate on wrong way");
                ref_meta[w][idx].valid = 1'b0;
                if (act == ACT_INVALIDATE) begin
                    @(negedge clock);
                end
                else begin
                    check(snoop_resp.msg == ((msg == REQ_FLUSH) ? C_FLUSH : C_WB),
                          "wrong writeback message");
                    check(snoop_resp.address == la, "wrong writeback address");
                    check(snoop_data == ref_data[w][idx], "wrong writeback data");
                    abort = (($random(seed) & 7) == 0);
                    pulse_intf(abort ? REQ_FLUSH : MEM_RESP, $random(seed) & 3);
                    if (abort)
                        check(snoop_resp == bus_req_t'{msg: NO_REQ, address: '0},
                              "abort left a response");
                    else if (l < lines - 1)
                        check(snoop_resp.msg == HOLD_BUS, "no HOLD_BUS after MEM_RESP");
                    else
                        check(snoop_resp.msg == EN_ACCESS, "no EN_ACCESS after MEM_RESP");
                end
            end
        end
        if (abort) begin
            repeat (6) begin
                @(negedge clock);
                check(!port1_read && !port1_write && !port1_invalidate,
                      "port1 activity after abort");
            end
        end
        else if (!stuck) begin
            wait_for(3, EN_ACCESS, "EN_ACCESS");
            check(snoop_resp.address == addr, "EN_ACCESS with wrong address");
            check(snoop_data == '0, "data sent with EN_ACCESS");
            hold = $random(seed) & 3;
            repeat (hold) begin
                @(negedge clock);
                check(snoop_resp.msg == EN_ACCESS, "EN_ACCESS dropped before req_ready");
            end
            @(posedge clock);
            req_ready <= 1'b1;
            @(posedge clock);
            req_ready <= 1'b0;
            @(negedge clock);
            check(snoop_resp.msg == NO_REQ && snoop_data == '0, "response kept after req_ready");
        end
        check(u_lx_snooper.u_fsm.state == IDLE, "FSM not back in IDLE");
        for (int s = 0; s < 256; s++)
            for (int v = 0; v < 2; v++)
                check(u_array.meta_mem[v][s] == ref_meta[v][s] &&
                      u_array.data_mem[v][s] == ref_data[v][s], "array differs from model");
        $display("test %0d %s offset %0d lines %0d: %s, fsm %s", t, msg.name(), off, lines,
                 (errors == err0) ? "ok" : "errors", u_lx_snooper.u_fsm.state.name());
    endtask

    initial begin
        seed        = 96;
        errors      = 0;
        checks      = 0;
        stuck       = 1'b0;
        reset       = 1'b1;
        bus_req     = '{msg: NO_REQ, address: '0};
        req_ready   = 1'b0;
        bus_master  = 1'b0;
        curr_offset = '0;
        intf_msg    = NO_REQ;
        fill_arrays();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check(!port1_read && !port1_write && !port1_invalidate, "port1 strobe after reset");
        check(snoop_resp.msg == NO_REQ && u_lx_snooper.u_fsm.state == IDLE,
              "response or FSM not cleared by reset");
        for (int t = 0; t < NUM_REQ && !stuck; t++)
            run_request(t);
        $display("requests %0d, checks %0d, errors %0d", NUM_REQ, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
